/* reg_access.f */
common/reg_access_pkg.sv
regfile/gpr_file.sv
regfile/segment_file.sv
rtl/hazard_scoreboard.sv
rtl/stack_pointer_unit.sv
rtl/reg_access_stage.sv
bench/reg_access_chk.sv
bench/reg_access_tb.sv

/* bench/reg_access_tb.sv */
// Testbench for the register access stage.
// A shadow model runs on the falling edge. Inputs change 1 unit after the rising edge.
// Random values come from a 32-bit Fibonacci LFSR with a fixed seed.
`default_nettype none

module reg_access_tb
    import reg_access_pkg::*;
();

    localparam int bw = $bits(issue_bundle_t);
    // Rough cycle budget of the six tests, in test order
    localparam int test_len_sum = 60 + 40 + 40 + 40 + 120 + 30;

    logic           clk;
    logic           rst_n;
    logic           flush;
    logic           d_valid;
    logic           d_ready;
    decode_bundle_t d_bundle;
    logic           r_valid;
    logic           r_ready;
    issue_bundle_t  r_bundle;
    gpr_wb_t        gpr_wb;
    seg_wb_t        seg_wb;
    logic           cs_load;
    logic [15:0]    cs_value;

    // Shadow state of the stage
    logic [31:0]    sh_gpr [num_gpr];
    logic [15:0]    sh_seg [num_seg];
    int             sh_pend [num_gpr];
    logic [31:0]    sh_esp;
    logic           sh_rvalid;
    issue_bundle_t  exp_q [$];

    logic [31:0]    lfsr_state;
    logic           bp_mode;
    string          cur_test;
    int             err_count;
    int             test_err_start;
    int             pass_tests;
    int             fail_tests;

    reg_access_stage DUT (
        .clk     (clk),
        .rst_n   (rst_n),
        .flush   (flush),
        .d_valid (d_valid),
        .d_ready (d_ready),
        .d_bundle(d_bundle),
        .r_valid (r_valid),
        .r_ready (r_ready),
        .r_bundle(r_bundle),
        .gpr_wb  (gpr_wb),
        .seg_wb  (seg_wb),
        .cs_load (cs_load),
        .cs_value(cs_value)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    task automatic check_value(input string name, input logic [bw-1:0] exp_v,
                               input logic [bw-1:0] act_v);
        if (act_v !== exp_v) begin
            err_count++;
            $display("MISMATCH %s expected %0h actual %0h", name, exp_v, act_v);
        end
    endtask

    function automatic reg_idx_t src_of(input operand_kind_e k, input reg_idx_t r,
                                        input logic [7:0] modrm);
        return (k == kind_modrm_reg) ? modrm[2:0] : r;
    endfunction

    function automatic logic names_reg(input operand_kind_e k);
        return (k == kind_decode_reg) || (k == kind_modrm_reg);
    endfunction

    function automatic logic expected_stall(input decode_bundle_t d);
        logic busy;
        busy = names_reg(d.op0_kind) && (sh_pend[src_of(d.op0_kind, d.op0_reg, d.modrm)] != 0);
        busy |= names_reg(d.op1_kind) && (sh_pend[src_of(d.op1_kind, d.op1_reg, d.modrm)] != 0);
        busy |= ((d.stack_op == stack_push) || (d.stack_op == stack_pop)) &&
                (sh_pend[esp_idx] != 0);
        return busy;
    endfunction

    function automatic issue_bundle_t expected_issue(input decode_bundle_t d);
        issue_bundle_t e;
        seg_idx_e      sel;
        logic [31:0]   step;
        logic [31:0]   offset;
        e.size               = d.size;
        e.op0_kind           = d.op0_kind;
        e.op1_kind           = d.op1_kind;
        e.op0_reg            = d.op0_reg;
        e.op1_reg            = d.op1_reg;
        e.modrm              = d.modrm;
        e.imm                = d.imm;
        e.disp               = d.disp;
        e.alu_op             = d.alu_op;
        e.stack_op           = d.stack_op;
        e.seg_override       = d.seg_override;
        e.seg_override_valid = d.seg_override_valid;
        e.pc                 = d.pc;
        e.src0_reg           = src_of(d.op0_kind, d.op0_reg, d.modrm);
        e.src1_reg           = src_of(d.op1_kind, d.op1_reg, d.modrm);
        e.op0_value          = sh_gpr[e.src0_reg];
        e.op1_value          = sh_gpr[e.src1_reg];
        if (d.seg_override_valid) begin
            sel = d.seg_override;
        end else if (d.stack_op != stack_none) begin
            sel = seg_ss;
        end else begin
            sel = seg_ds;
        end
        e.seg_value = (int'(sel) < num_seg) ? sh_seg[sel] : 16'd0;
        step   = (d.size == size_dword) ? 32'd4 : 32'd2;
        offset = (d.stack_op == stack_push) ? sh_esp - step : sh_esp;
        e.stack_address = {12'd0, sh_seg[seg_ss], 4'd0} + offset;
        return e;
    endfunction

    // State after the coming rising edge
    task automatic update_shadow(input logic acc);
        logic [31:0] step;
        logic        esp_wb;
        step   = (d_bundle.size == size_dword) ? 32'd4 : 32'd2;
        esp_wb = gpr_wb.en && !gpr_wb.stack && (gpr_wb.reg_num == esp_idx);
        if (flush) begin
            sh_esp = sh_gpr[esp_idx];
        end else if (esp_wb && (gpr_wb.size == size_dword)) begin
            sh_esp = gpr_wb.data;
        end else if (esp_wb && (gpr_wb.size == size_word)) begin
            sh_esp[15:0] = gpr_wb.data[15:0];
        end else if (acc && (d_bundle.stack_op == stack_push)) begin
            sh_esp = sh_esp - step;
        end else if (acc && (d_bundle.stack_op == stack_pop)) begin
            sh_esp = sh_esp + step;
        end
        if (gpr_wb.en) begin
            case (gpr_wb.size)
                size_dword: sh_gpr[gpr_wb.reg_num] = gpr_wb.data;
                size_word:  sh_gpr[gpr_wb.reg_num][15:0] = gpr_wb.data[15:0];
                size_byte: begin
                    // 4..7 are AH, CH, DH, BH
                    if (gpr_wb.reg_num[2]) begin
                        sh_gpr[gpr_wb.reg_num - 3'd4][15:8] = gpr_wb.data[7:0];
                    end else begin
                        sh_gpr[gpr_wb.reg_num][7:0] = gpr_wb.data[7:0];
                    end
                end
                default: begin
                end
            endcase
        end
        if (seg_wb.en && (int'(seg_wb.seg) < num_seg)) begin
            sh_seg[seg_wb.seg] = seg_wb.data;
        end
        if (cs_load) begin
            sh_seg[seg_cs] = cs_value;
        end
        for (int i = 0; i < num_gpr; i++) begin
            if (flush) begin
                sh_pend[i] = 0;
            end else begin
                sh_pend[i] += (acc && d_bundle.dest_valid && (d_bundle.dest_reg == i)) ? 1 : 0;
                sh_pend[i] -= (gpr_wb.en && !gpr_wb.stack && (gpr_wb.reg_num == i)) ? 1 : 0;
            end
        end
        if (flush) begin
            sh_rvalid = 1'b0;
            exp_q.delete();
        end else if (acc) begin
            sh_rvalid = 1'b1;
        end else if (r_ready) begin
            sh_rvalid = 1'b0;
        end
    endtask

    // Shadow model and compare, on the falling edge where all signals are settled
    always @(negedge clk) begin : compare
        logic          exp_ready;
        logic          acc;
        issue_bundle_t exp_b;
        if (!rst_n) begin
            for (int i = 0; i < num_gpr; i++) begin
                sh_gpr[i]  = '0;
                sh_pend[i] = 0;
            end
            for (int i = 0; i < num_seg; i++) begin
                sh_seg[i] = '0;
            end
            sh_esp    = '0;
            sh_rvalid = 1'b0;
            exp_q.delete();
        end else begin
            exp_ready = !(d_valid && expected_stall(d_bundle)) && !flush &&
                        (!sh_rvalid || r_ready);
            acc = d_valid && exp_ready;
            check_value({cur_test, " d_ready"}, exp_ready, d_ready);
            check_value({cur_test, " r_valid"}, sh_rvalid, r_valid);
            if (r_valid && r_ready) begin
                if (exp_q.size() == 0) begin
                    err_count++;
                    $display("%s: a bundle left the stage with no accepted instruction for it",
                             cur_test);
                end else begin
                    exp_b = exp_q.pop_front();
                    check_value(cur_test, exp_b, r_bundle);
                end
            end
            if (acc) begin
                exp_q.push_back(expected_issue(d_bundle));
            end
            update_shadow(acc);
        end
    end

    task automatic tick();
        @(posedge clk);
        #1;
        gpr_wb.en = 1'b0;
        seg_wb.en = 1'b0;
        cs_load   = 1'b0;
        flush     = 1'b0;
        if (bp_mode) begin
            r_ready = (rand_bits(1) != 0);
        end
    endtask

    task automatic wait_accept();
        logic taken;
        taken = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = d_ready;
            tick();
        end
        d_valid = 1'b0;
    endtask

    task automatic issue(input decode_bundle_t b);
        d_bundle = b;
        d_valid  = 1'b1;
        wait_accept();
    endtask

    task automatic write_gpr(input reg_idx_t r, input op_size_e sz, input logic [31:0] data,
                             input logic stack);
        gpr_wb.en      = 1'b1;
        gpr_wb.stack   = stack;
        gpr_wb.reg_num = r;
        gpr_wb.size    = sz;
        gpr_wb.data    = data;
        tick();
    endtask

    task automatic write_seg(input seg_idx_e s, input logic [15:0] data, input logic load_cs,
                             input logic [15:0] cs_v);
        seg_wb.en   = 1'b1;
        seg_wb.seg  = s;
        seg_wb.data = data;
        cs_load     = load_cs;
        cs_value    = cs_v;
        tick();
    endtask

    // Two register operands, no destination, no stack operation
    function automatic decode_bundle_t rand_bundle();
        decode_bundle_t b;
        b          = '0;
        b.size     = (rand_bits(1) != 0) ? size_dword : size_word;
        b.op0_kind = kind_decode_reg;
        b.op1_kind = kind_decode_reg;
        b.op0_reg  = reg_idx_t'(rand_bits(3));
        b.op1_reg  = reg_idx_t'(rand_bits(3));
        b.modrm    = 8'(rand_bits(8));
        b.imm      = rand_bits(32);
        b.disp     = rand_bits(32);
        b.alu_op   = 4'(rand_bits(4));
        b.pc       = rand_bits(32);
        return b;
    endfunction

    task automatic begin_test(input string name);
        cur_test       = name;
        test_err_start = err_count;
    endtask

    // Keeps stepping the clock so that random back-pressure can release
    task automatic end_test();
        int waited;
        waited = 0;
        while ((exp_q.size() != 0) && (waited < 100)) begin
            tick();
            waited++;
        end
        if (exp_q.size() != 0) begin
            err_count++;
            $display("%s: %0d accepted instructions never left the stage", cur_test,
                     exp_q.size());
        end
        tick();
        if (err_count == test_err_start) begin
            pass_tests++;
            $display("test %s: ok", cur_test);
        end else begin
            fail_tests++;
            $display("test %s: failed with %0d errors", cur_test, err_count - test_err_start);
        end
    endtask

    initial begin : watchdog
        repeat (test_len_sum * 4 + 10) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d cycles", test_len_sum * 4 + 10);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin : stimulus
        decode_bundle_t b;
        logic [1:0]     sz;
        reg_idx_t       r;
        rst_n      = 1'b0;
        flush      = 1'b0;
        d_valid    = 1'b0;
        d_bundle   = '0;
        r_ready    = 1'b1;
        gpr_wb     = '0;
        seg_wb     = '0;
        cs_load    = 1'b0;
        cs_value   = '0;
        bp_mode    = 1'b0;
        lfsr_state = 32'd81017;
        err_count  = 0;
        pass_tests = 0;
        fail_tests = 0;
        cur_test   = "reset";
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        tick();

        begin_test("sized_writeback");
        for (int i = 0; i < 14; i++) begin
            sz = 2'(rand_bits(2));
            r  = (i < 2) ? reg_idx_t'(5 + 2 * i) : reg_idx_t'(rand_bits(3));
            // First two writes hit CH and BH
            write_gpr(r, (i < 2) ? size_byte : op_size_e'((sz == 2'd3) ? 2'd2 : sz),
                      rand_bits(32), 1'b1);
            b = rand_bundle();
            b.op0_reg = r;
            b.op1_reg = {1'b0, r[1:0]};
            issue(b);
        end
        end_test();

        begin_test("register_select");
        for (int s = 0; s < num_seg; s++) begin
            write_seg(seg_idx_e'(s), 16'(rand_bits(16)), 1'b0, 16'd0);
        end
        // Direct CS load against a same-edge CS writeback
        write_seg(seg_cs, 16'(rand_bits(16)), 1'b1, 16'(rand_bits(16)));
        for (int i = 0; i < 12; i++) begin
            b = rand_bundle();
            b.op0_kind = kind_modrm_reg;
            b.op1_kind = (i % 2 == 0) ? kind_decode_reg : kind_modrm_reg;
            case (i % 3)
                0: begin
                    b.seg_override_valid = 1'b1;
                    b.seg_override       = seg_idx_e'(rand_bits(32) % num_seg);
                end
                1: b.stack_op = (i % 2 == 0) ? stack_push : stack_pop;
                default: begin
                end
            endcase
            issue(b);
        end
        b = rand_bundle();
        b.seg_override_valid = 1'b1;
        b.seg_override       = seg_cs;
        issue(b);
        end_test();

        begin_test("hazard_stall");
        for (int i = 0; i < 3; i++) begin
            r = reg_idx_t'(rand_bits(3));
            b = rand_bundle();
            b.dest_valid = 1'b1;
            b.dest_reg   = r;
            issue(b);
            b = rand_bundle();
            b.op0_reg = r;
            d_bundle  = b;
            d_valid   = 1'b1;
            repeat (4) begin
                @(negedge clk);
                check_value({cur_test, " reader held"}, 1'b0, d_ready);
                tick();
            end
            write_gpr(r, size_dword, rand_bits(32), 1'b0);
            wait_accept();
        end
        end_test();

        begin_test("stack");
        write_seg(seg_ss, 16'(rand_bits(16)), 1'b0, 16'd0);
        for (int i = 0; i < 10; i++) begin
            b = rand_bundle();
            b.op0_kind = kind_none;
            b.op1_kind = kind_none;
            b.stack_op = (i < 3 || rand_bits(1) != 0) ? stack_push : stack_pop;
            issue(b);
            if (i == 4) begin
                // MOV to ESP, its writeback reloads the working copy
                b = rand_bundle();
                b.dest_valid = 1'b1;
                b.dest_reg   = esp_idx;
                issue(b);
                write_gpr(esp_idx, size_dword, rand_bits(32), 1'b0);
            end
            if (i == 7) begin
                write_gpr(esp_idx, size_dword, rand_bits(32), 1'b1);
            end
        end
        end_test();

        begin_test("back_pressure");
        bp_mode = 1'b1;
        for (int i = 0; i < 20; i++) begin
            issue(rand_bundle());
        end
        end_test();
        bp_mode = 1'b0;
        r_ready = 1'b1;

        begin_test("flush");
        b = rand_bundle();
        b.op0_kind = kind_none;
        b.op1_kind = kind_none;
        b.stack_op = stack_push;
        issue(b);
        r = reg_idx_t'(rand_bits(2));
        b = rand_bundle();
        b.dest_valid = 1'b1;
        b.dest_reg   = r;
        issue(b);
        r_ready = 1'b0;
        tick();
        flush = 1'b1;
        tick();
        @(negedge clk);
        check_value({cur_test, " r_valid after flush"}, 1'b0, r_valid);
        tick();
        r_ready = 1'b1;
        b = rand_bundle();
        b.op0_reg = r;
        issue(b);
        b = rand_bundle();
        b.op0_kind = kind_none;
        b.op1_kind = kind_none;
        b.stack_op = stack_push;
        issue(b);
        end_test();

        $display("tests passed %0d, failed %0d, errors %0d, assertion failures %0d",
                 pass_tests, fail_tests, err_count, DUT.u_chk.assert_fails);
        if ((err_count == 0) && (fail_tests == 0) && (DUT.u_chk.assert_fails == 0)) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* bench/reg_access_chk.sv */
// Handshake and stall properties of reg_access_stage, bound into each instance.
// The stall input is the stage's internal scoreboard stall.
`default_nettype none

module reg_access_chk
    import reg_access_pkg::*;
(
    input wire           clk,
    input wire           rst_n,
    input wire           flush,
    input wire           stall,
    input wire           d_ready,
    input wire           r_valid,
    input wire           r_ready,
    input issue_bundle_t r_bundle
);

    int assert_fails = 0;

    // Held output bundle must not move
    a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (r_valid && !r_ready) |=> $stable(r_bundle))
    else begin
        assert_fails++;
        $error("r_bundle changed while r_valid was high and r_ready low");
    end

    a_flush_empties: assert property (@(posedge clk) disable iff (!rst_n)
        flush |=> !r_valid)
    else begin
        assert_fails++;
        $error("r_valid still high in the cycle after flush");
    end

    // Flush drops every pending write, so nothing can stall right after it
    a_flush_clears_stall: assert property (@(posedge clk) disable iff (!rst_n)
        flush |=> !stall)
    else begin
        assert_fails++;
        $error("scoreboard still stalls in the cycle after flush");
    end

endmodule

bind reg_access_stage reg_access_chk u_chk (
    .clk     (clk),
    .rst_n   (rst_n),
    .flush   (flush),
    .stall   (stall),
    .d_ready (d_ready),
    .r_valid (r_valid),
    .r_ready (r_ready),
    .r_bundle(r_bundle)
);

`default_nettype wire

/* rtl/reg_access_stage.sv */
// Register access stage between decode and address generation.
// Operands are read in the accept cycle and leave one cycle later.
// d_ready depends on d_valid through the stall, and drops while flush is high.
`default_nettype none

module reg_access_stage
    import reg_access_pkg::*;
(
    input  wire            clk,
    input  wire            rst_n,
    input  wire            flush,
    input  wire            d_valid,
    output logic           d_ready,
    input  decode_bundle_t d_bundle,
    output logic           r_valid,
    input  wire            r_ready,
    output issue_bundle_t  r_bundle,
    input  gpr_wb_t        gpr_wb,
    input  seg_wb_t        seg_wb,
    input  wire            cs_load,
    input  wire     [15:0] cs_value
);

    logic [31:0]    regs [num_gpr];
    logic [15:0]    segs [num_seg];
    decode_bundle_t resolved;
    issue_bundle_t  issue_next;
    reg_idx_t       src0_reg;
    reg_idx_t       src1_reg;
    seg_idx_e       seg_sel;
    logic [15:0]    seg_value;
    logic [31:0]    stack_address;
    logic           stall;
    logic           accept;

    gpr_file u_gpr_file (
        .clk  (clk),
        .rst_n(rst_n),
        .wb   (gpr_wb),
        .regs (regs)
    );

    segment_file u_segment_file (
        .clk     (clk),
        .rst_n   (rst_n),
        .wb      (seg_wb),
        .cs_load (cs_load),
        .cs_value(cs_value),
        .segs    (segs)
    );

    // ModRM kind takes the r/m field as the register number
    assign src0_reg = (d_bundle.op0_kind == kind_modrm_reg) ? d_bundle.modrm[2:0] :
                      d_bundle.op0_reg;
    assign src1_reg = (d_bundle.op1_kind == kind_modrm_reg) ? d_bundle.modrm[2:0] :
                      d_bundle.op1_reg;

    always_comb begin
        resolved         = d_bundle;
        resolved.op0_reg = src0_reg;
        resolved.op1_reg = src1_reg;
    end

    hazard_scoreboard u_hazard_scoreboard (
        .clk     (clk),
        .rst_n   (rst_n),
        .flush   (flush),
        .d_valid (d_valid),
        .d_bundle(resolved),
        .accept  (accept),
        .gpr_wb  (gpr_wb),
        .stall   (stall)
    );

    stack_pointer_unit u_stack_pointer_unit (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush        (flush),
        .accept       (accept),
        .size         (d_bundle.size),
        .stack_op     (d_bundle.stack_op),
        .committed_esp(regs[esp_idx]),
        .ss           (segs[seg_ss]),
        .gpr_wb       (gpr_wb),
        .stack_address(stack_address)
    );

    // Override first, then SS for stack ops, DS otherwise
    always_comb begin
        seg_sel = seg_ds;
        if (d_bundle.seg_override_valid) begin
            seg_sel = d_bundle.seg_override;
        end else if (d_bundle.stack_op != stack_none) begin
            seg_sel = seg_ss;
        end
        seg_value = (int'(seg_sel) < num_seg) ? segs[seg_sel] : 16'd0;
    end

    always_comb begin
        issue_next.size               = d_bundle.size;
        issue_next.op0_kind           = d_bundle.op0_kind;
        issue_next.op1_kind           = d_bundle.op1_kind;
        issue_next.op0_reg            = d_bundle.op0_reg;
        issue_next.op1_reg            = d_bundle.op1_reg;
        issue_next.modrm              = d_bundle.modrm;
        issue_next.imm                = d_bundle.imm;
        issue_next.disp               = d_bundle.disp;
        issue_next.alu_op             = d_bundle.alu_op;
        issue_next.stack_op           = d_bundle.stack_op;
        issue_next.seg_override       = d_bundle.seg_override;
        issue_next.seg_override_valid = d_bundle.seg_override_valid;
        issue_next.pc                 = d_bundle.pc;
        issue_next.src0_reg           = src0_reg;
        issue_next.src1_reg           = src1_reg;
        issue_next.op0_value          = regs[src0_reg];
        issue_next.op1_value          = regs[src1_reg];
        issue_next.seg_value          = seg_value;
        issue_next.stack_address      = stack_address;
    end

    // Flush in ready keeps every handshake an accept
    assign d_ready = !stall && !flush && (!r_valid || r_ready);
    assign accept  = d_valid && d_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            r_valid <= 1'b0;
        end else if (flush) begin
            r_valid <= 1'b0;
        end else if (accept) begin
            r_valid <= 1'b1;
        end else if (r_ready) begin
            r_valid <= 1'b0;
        end
    end

    // Payload only moves on an accept
    always_ff @(posedge clk) begin
        if (accept) begin
            r_bundle <= issue_next;
        end
    end

endmodule

`default_nettype wire

/* rtl/stack_pointer_unit.sv */
// Working ESP for PUSH and POP, running ahead of the committed ESP.
// A byte-sized writeback to number 4 hits AH and leaves the working ESP alone.
// On flush the committed value is taken as it stands before that edge.
`default_nettype none

module stack_pointer_unit
    import reg_access_pkg::*;
(
    input  wire         clk,
    input  wire         rst_n,
    input  wire         flush,
    input  wire         accept,
    input  op_size_e    size,
    input  stack_op_e   stack_op,
    input  wire  [31:0] committed_esp,
    input  wire  [15:0] ss,
    input  gpr_wb_t     gpr_wb,
    output logic [31:0] stack_address
);

    logic [31:0] work_esp;
    logic [31:0] step;
    logic [31:0] pushed_esp;
    logic [31:0] popped_esp;
    logic [31:0] offset;
    logic [31:0] seg_base;
    logic        esp_wb;
    logic [31:0] esp_wb_value;

    // Byte pushes move the pointer by 2, like word
    assign step       = (size == size_dword) ? 32'd4 : 32'd2;
    assign pushed_esp = work_esp - step;
    assign popped_esp = work_esp + step;

    assign esp_wb = gpr_wb.en && !gpr_wb.stack && (gpr_wb.reg_num == esp_idx) &&
                    (gpr_wb.size != size_byte);
    assign esp_wb_value = (gpr_wb.size == size_dword) ? gpr_wb.data :
                          {work_esp[31:16], gpr_wb.data[15:0]};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            work_esp <= '0;
        end else if (flush) begin
            work_esp <= committed_esp;
        end else if (esp_wb) begin
            work_esp <= esp_wb_value;
        end else if (accept && (stack_op == stack_push)) begin
            work_esp <= pushed_esp;
        end else if (accept && (stack_op == stack_pop)) begin
            work_esp <= popped_esp;
        end
    end

    // Push addresses the new top, pop the old one
    assign offset        = (stack_op == stack_push) ? pushed_esp : work_esp;
    assign seg_base      = {12'd0, ss, 4'd0};
    assign stack_address = seg_base + offset;

endmodule

`default_nettype wire

/* rtl/hazard_scoreboard.sv */
// Pending-write counters for the general registers and the stall decision.
// Counters neither saturate nor guard against underflow. Decode keeps at most
// three writes in flight to one register. Sources arrive already resolved.
`default_nettype none

module hazard_scoreboard
    import reg_access_pkg::*;
(
    input  wire            clk,
    input  wire            rst_n,
    input  wire            flush,
    input  wire            d_valid,
    input  decode_bundle_t d_bundle,
    input  wire            accept,
    input  gpr_wb_t        gpr_wb,
    output logic           stall
);

    logic [pending_cnt_w-1:0] pend_cnt [num_gpr];
    logic [num_gpr-1:0]       inc_vec;
    logic [num_gpr-1:0]       dec_vec;
    logic                     src0_used;
    logic                     src1_used;
    logic                     esp_used;
    logic                     src0_busy;
    logic                     src1_busy;
    logic                     esp_busy;

    always_comb begin
        for (int i = 0; i < num_gpr; i++) begin
            inc_vec[i] = accept && d_bundle.dest_valid && (d_bundle.dest_reg == reg_idx_t'(i));
            dec_vec[i] = gpr_wb.en && !gpr_wb.stack && (gpr_wb.reg_num == reg_idx_t'(i));
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < num_gpr; i++) begin
                pend_cnt[i] <= '0;
            end
        end else if (flush) begin
            for (int i = 0; i < num_gpr; i++) begin
                pend_cnt[i] <= '0;
            end
        end else begin
            // Same-edge increment and decrement cancel out
            for (int i = 0; i < num_gpr; i++) begin
                if (inc_vec[i] && !dec_vec[i]) begin
                    pend_cnt[i] <= pend_cnt[i] + 1'b1;
                end else if (dec_vec[i] && !inc_vec[i]) begin
                    pend_cnt[i] <= pend_cnt[i] - 1'b1;
                end
            end
        end
    end

    // A source counts only when it names a register
    assign src0_used = (d_bundle.op0_kind == kind_decode_reg) ||
                       (d_bundle.op0_kind == kind_modrm_reg);
    assign src1_used = (d_bundle.op1_kind == kind_decode_reg) ||
                       (d_bundle.op1_kind == kind_modrm_reg);
    assign esp_used  = (d_bundle.stack_op == stack_push) ||
                       (d_bundle.stack_op == stack_pop);

    assign src0_busy = src0_used && (pend_cnt[d_bundle.op0_reg] != '0);
    assign src1_busy = src1_used && (pend_cnt[d_bundle.op1_reg] != '0);
    assign esp_busy  = esp_used && (pend_cnt[esp_idx] != '0);

    assign stall = d_valid && (src0_busy || src1_busy || esp_busy);

endmodule

`default_nettype wire

/* regfile/segment_file.sv */
// Six 16-bit segment registers, all read in parallel.
// Writes to numbers 6 and 7 are dropped. A direct CS load wins over a
// writeback to CS on the same edge.
`default_nettype none

module segment_file
    import reg_access_pkg::*;
(
    input  wire         clk,
    input  wire         rst_n,
    input  seg_wb_t     wb,
    input  wire         cs_load,
    input  wire  [15:0] cs_value,
    output logic [15:0] segs [num_seg]
);

    logic wb_hit;

    assign wb_hit = wb.en && (int'(wb.seg) < num_seg);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < num_seg; i++) begin
                segs[i] <= '0;
            end
        end else begin
            if (wb_hit) begin
                segs[wb.seg] <= wb.data;
            end
            // Far jump target, last so it overrides the writeback
            if (cs_load) begin
                segs[seg_cs] <= cs_value;
            end
        end
    end

endmodule

`default_nettype wire

/* regfile/gpr_file.sv */
// Eight 32-bit general registers, all read in parallel.
// A byte write to numbers 4..7 lands in AH, CH, DH or BH.
// A write with the stack bit set is applied like any other write.
`default_nettype none

module gpr_file
    import reg_access_pkg::*;
(
    input  wire         clk,
    input  wire         rst_n,
    input  gpr_wb_t     wb,
    output logic [31:0] regs [num_gpr]
);

    // Byte writes to 4..7 go to the high byte of register minus 4
    reg_idx_t   byte_target;
    logic       byte_high;
    logic [7:0] byte_data;

    assign byte_high   = wb.reg_num[2];
    assign byte_target = {1'b0, wb.reg_num[1:0]};
    assign byte_data   = wb.data[7:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < num_gpr; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.en) begin
            case (wb.size)
                size_dword: begin
                    regs[wb.reg_num] <= wb.data;
                end
                size_word: begin
                    regs[wb.reg_num][15:0] <= wb.data[15:0];
                end
                size_byte: begin
                    if (byte_high) begin
                        regs[byte_target][15:8] <= byte_data;
                    end else begin
                        regs[byte_target][7:0] <= byte_data;
                    end
                end
                default: begin
                    // Undefined size code, no write
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* common/reg_access_pkg.sv */
// Shared types and sizes for the register access stage.
// The writeback register field is named reg_num, because reg is a keyword.
// Segment numbers 6 and 7 do not name a register. Reads of them return zero.
`default_nettype none

package reg_access_pkg;

    localparam int num_gpr = 8;
    localparam int num_seg = 6;
    localparam int pending_cnt_w = 2;

    typedef logic [2:0] reg_idx_t;

    localparam reg_idx_t esp_idx = 3'd4;

    typedef enum logic [1:0] {
        size_byte  = 2'd0,
        size_word  = 2'd1,
        size_dword = 2'd2
    } op_size_e;

    // Encoding 4 selects the ModRM r/m field as the register number
    typedef enum logic [2:0] {
        kind_none       = 3'd0,
        kind_decode_reg = 3'd1,
        kind_imm        = 3'd2,
        kind_mem        = 3'd3,
        kind_modrm_reg  = 3'd4
    } operand_kind_e;

    typedef enum logic [1:0] {
        stack_none = 2'd0,
        stack_push = 2'd1,
        stack_pop  = 2'd2
    } stack_op_e;

    typedef enum logic [2:0] {
        seg_es = 3'd0,
        seg_cs = 3'd1,
        seg_ss = 3'd2,
        seg_ds = 3'd3,
        seg_fs = 3'd4,
        seg_gs = 3'd5
    } seg_idx_e;

    typedef struct packed {
        op_size_e      size;
        operand_kind_e op0_kind;
        operand_kind_e op1_kind;
        reg_idx_t      op0_reg;
        reg_idx_t      op1_reg;
        logic [7:0]    modrm;
        logic [31:0]   imm;
        logic [31:0]   disp;
        logic [3:0]    alu_op;
        stack_op_e     stack_op;
        seg_idx_e      seg_override;
        logic          seg_override_valid;
        reg_idx_t      dest_reg;
        logic          dest_valid;
        logic [31:0]   pc;
    } decode_bundle_t;

    typedef struct packed {
        op_size_e      size;
        operand_kind_e op0_kind;
        operand_kind_e op1_kind;
        reg_idx_t      op0_reg;
        reg_idx_t      op1_reg;
        logic [7:0]    modrm;
        logic [31:0]   imm;
        logic [31:0]   disp;
        logic [3:0]    alu_op;
        stack_op_e     stack_op;
        seg_idx_e      seg_override;
        logic          seg_override_valid;
        logic [31:0]   pc;
        reg_idx_t      src0_reg;
        reg_idx_t      src1_reg;
        logic [31:0]   op0_value;
        logic [31:0]   op1_value;
        logic [15:0]   seg_value;
        logic [31:0]   stack_address;
    } issue_bundle_t;

    typedef struct packed {
        logic        en;
        logic        stack;
        reg_idx_t    reg_num;
        op_size_e    size;
        logic [31:0] data;
    } gpr_wb_t;

    typedef struct packed {
        logic        en;
        seg_idx_e    seg;
        logic [15:0] data;
    } seg_wb_t;

endpackage

`default_nettype wire
